// File: design/apbFeatureWriter.sv
`timescale 1ns/1ps
`default_nettype none

module apbFeatureWriter (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [nnPkg::AddrWidth-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic featPush,
	output nnPkg::featureVec_t featData,
	input logic featFull,
	input nnPkg::resultVec_t resultHead,
	input logic resultEmpty,
	input logic [nnPkg::CountWidth-1:0] resultCount,
	output logic resultPop
);
	import nnPkg::*;

	localparam int FeatIdxW = $clog2(NumInputs);
	localparam int ResIdxW = $clog2(NumNodes);

	featureVec_t featRegs;
	logic access;
	logic [AddrWidth-1:0] featOffset;
	logic [AddrWidth-1:0] resultOffset;
	logic [FeatIdxW-1:0] featIdx;
	logic [ResIdxW-1:0] resultIdx;
	logic featHit;
	logic commitHit;
	logic statusHit;
	logic resultHit;
	logic popHit;
	logic mapped;
	logic emptyErr;
	logic [31:0] statusWord;

	assign access = psel & penable;

	// address decode, offsets keep the range checks one-sided
	assign featOffset = paddr - FeatAddr;
	assign resultOffset = paddr - ResultAddr;
	assign featIdx = featOffset[FeatIdxW+1:2];
	assign resultIdx = resultOffset[ResIdxW+1:2];

	assign featHit = (featOffset < AddrWidth'(4 * NumInputs)) && (featOffset[1:0] == 2'b00);
	assign commitHit = (paddr == CommitAddr) && pwrite;
	assign statusHit = (paddr == StatusAddr) && !pwrite;
	assign resultHit = (resultOffset < AddrWidth'(4 * NumNodes)) && (resultOffset[1:0] == 2'b00)
		&& !pwrite;
	assign popHit = (paddr == PopAddr) && pwrite;

	assign mapped = featHit | commitHit | statusHit | resultHit | popHit;
	assign emptyErr = (resultHit | popHit) & resultEmpty;

	// only a commit into a full feature queue waits
	assign pready = !(access && commitHit && featFull);
	assign pslverr = access && (!mapped || emptyErr);

	assign featPush = access & commitHit & ~featFull;
	assign resultPop = access & popHit & ~resultEmpty;
	assign featData = featRegs;

	assign statusWord = {{(24 - CountWidth){1'b0}}, resultCount, 6'b0, featFull, !resultEmpty};

	always_comb
	begin
		prdata = '0;
		if (!pwrite)
		begin
			if (featHit)
				prdata = featRegs.feat[featIdx];
			else if (statusHit)
				prdata = statusWord;
			else if (resultHit && !resultEmpty)
				prdata = resultHead.act[resultIdx];
		end
	end

	// feature registers survive a commit, so a vector can be resent as is
	always_ff @(posedge clk)
	begin
		if (reset)
			featRegs <= '0;
		else if (access && pwrite && featHit)
			featRegs.feat[featIdx] <= pwdata;
	end

endmodule

`default_nettype wire

// File: design/denseLayer.sv
`timescale 1ns/1ps
`default_nettype none

module denseLayer #(
	parameter nnPkg::layerWeights_t layerWeights = nnPkg::DefaultWeights,
	parameter int ResultDepth = 4
) (
	input logic clk,
	input logic reset,
	input nnPkg::featureVec_t featHead,
	input logic featEmpty,
	output logic featPop,
	input logic [nnPkg::CountWidth-1:0] resultFree,
	output logic resultPush,
	output nnPkg::resultVec_t resultData
);
	import nnPkg::*;

	// never more vectors in the pipe than it has stages or the result queue has slots
	localparam int MaxInFlight = (ResultDepth < NodeLatency) ? ResultDepth : NodeLatency;
	localparam int FlightW = $clog2(MaxInFlight + 1);

	logic [NodeLatency-1:0] validPipe;
	logic [FlightW-1:0] inFlight;
	word_t nodeOut [NumNodes];

	// nodes sample the queue head every cycle, validPipe says which samples count
	for (genvar n = 0; n < NumNodes; n++)
	begin : gNode
		reluNode #(
			.weights(layerWeights[n])
		) node (
			.clk(clk),
			.reset(reset),
			.features(featHead),
			.activation(nodeOut[n])
		);

		assign resultData.act[n] = nodeOut[n];
	end

	// credit check, every vector in flight already owns a result slot
	assign featPop = !featEmpty && (resultFree > CountWidth'(inFlight));

	assign resultPush = validPipe[NodeLatency-1]; // lines up with node outputs

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
			inFlight <= '0;
		end
		else
		begin
			validPipe <= {validPipe[NodeLatency-2:0], featPop};
			case ({featPop, resultPush})
				2'b10: inFlight <= inFlight + 1'b1;
				2'b01: inFlight <= inFlight - 1'b1;
				default: inFlight <= inFlight;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/nnLayerTop.sv
`timescale 1ns/1ps
`default_nettype none

module nnLayerTop #(
	parameter nnPkg::layerWeights_t layerWeights = nnPkg::DefaultWeights,
	parameter int FeatureDepth = 4,
	parameter int ResultDepth = 4
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [nnPkg::AddrWidth-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);
	import nnPkg::*;

	logic featPush;
	featureVec_t featData;
	logic featFull;
	featureVec_t featHead;
	logic featEmpty;
	logic featPop;

	logic resultPush;
	resultVec_t resultData;
	logic resultFull;
	resultVec_t resultHead;
	logic resultEmpty;
	logic resultPop;
	logic [CountWidth-1:0] resultCount;
	logic [CountWidth-1:0] resultFree;

	assign resultFree = CountWidth'(ResultDepth) - resultCount; // credits for the layer

	apbFeatureWriter apbWriter (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.featPush(featPush),
		.featData(featData),
		.featFull(featFull),
		.resultHead(resultHead),
		.resultEmpty(resultEmpty),
		.resultCount(resultCount),
		.resultPop(resultPop)
	);

	vectorQueue #(
		.payload_t(featureVec_t),
		.Depth(FeatureDepth)
	) featQueue (
		.clk(clk),
		.reset(reset),
		.push(featPush),
		.pushData(featData),
		.full(featFull),
		.pop(featPop),
		.head(featHead),
		.empty(featEmpty),
		.count()
	);

	denseLayer #(
		.layerWeights(layerWeights),
		.ResultDepth(ResultDepth)
	) layer (
		.clk(clk),
		.reset(reset),
		.featHead(featHead),
		.featEmpty(featEmpty),
		.featPop(featPop),
		.resultFree(resultFree),
		.resultPush(resultPush),
		.resultData(resultData)
	);

	vectorQueue #(
		.payload_t(resultVec_t),
		.Depth(ResultDepth)
	) resultQueue (
		.clk(clk),
		.reset(reset),
		.push(resultPush),
		.pushData(resultData),
		.full(resultFull),
		.pop(resultPop),
		.head(resultHead),
		.empty(resultEmpty),
		.count(resultCount)
	);

endmodule

`default_nettype wire

// File: design/nnPkg.sv
`default_nettype none

package nnPkg;

	parameter int NumInputs = 10;
	parameter int NumNodes = 4;
	parameter int NodeLatency = 3; // input, sum, relu registers

	parameter int AddrWidth = 8;
	parameter int CountWidth = 8; // queue occupancy, also the status count field

	typedef logic signed [31:0] word_t;

	typedef struct packed {
		word_t [0:NumInputs-1] feat;
	} featureVec_t;

	typedef struct packed {
		word_t [0:NumNodes-1] act;
	} resultVec_t;

	typedef struct packed {
		word_t [0:NumInputs-1] w;
		word_t bias;
	} nodeWeights_t;

	typedef nodeWeights_t [0:NumNodes-1] layerWeights_t;

	// APB register map
	parameter logic [AddrWidth-1:0] FeatAddr = 8'h00;
	parameter logic [AddrWidth-1:0] CommitAddr = 8'h28;
	parameter logic [AddrWidth-1:0] StatusAddr = 8'h2C;
	parameter logic [AddrWidth-1:0] ResultAddr = 8'h30;
	parameter logic [AddrWidth-1:0] PopAddr = 8'h40;

	// node 3 carries a big negative bias so relu clamps often
	parameter layerWeights_t DefaultWeights = '{
		'{w: '{8171, -37, -3058, 4838, 3271, 5075, -2606, -8192, -95, 4320},
			bias: 633},
		'{w: '{-1203, 2917, 640, -4471, 88, 3306, -7150, 1999, 5210, -316},
			bias: -412},
		'{w: '{4409, -5620, 1377, 250, -2204, 7781, 93, -3340, 6018, 1152},
			bias: 2048},
		'{w: '{-3390, 1046, -812, 2675, -5133, 407, 3890, -1720, 211, -6044},
			bias: -2000000000}
	};

endpackage

`default_nettype wire

// File: design/reluNode.sv
`timescale 1ns/1ps
`default_nettype none

module reluNode #(
	parameter nnPkg::nodeWeights_t weights = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::featureVec_t features,
	output nnPkg::word_t activation
);
	import nnPkg::*;

	featureVec_t featReg;
	word_t products [NumInputs];
	word_t sumNext;
	word_t sumReg;

	// products keep only their low 32 bits
	always_comb
	begin
		for (int i = 0; i < NumInputs; i++)
		begin
			products[i] = word_t'(featReg.feat[i] * weights.w[i]);
		end
	end

	always_comb
	begin
		sumNext = weights.bias;
		for (int i = 0; i < NumInputs; i++)
		begin
			sumNext = sumNext + products[i]; // wraps modulo 2^32
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			featReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			featReg <= features;
			sumReg <= sumNext;
			// sign bit alone picks the clamp
			if (sumReg[31])
				activation <= '0;
			else
				activation <= sumReg;
		end
	end

endmodule

`default_nettype wire

// File: design/vectorQueue.sv
`timescale 1ns/1ps
`default_nettype none

module vectorQueue #(
	parameter type payload_t = logic [31:0],
	parameter int Depth = 4
) (
	input logic clk,
	input logic reset,
	input logic push,
	input payload_t pushData,
	output logic full,
	input logic pop,
	output payload_t head,
	output logic empty,
	output logic [nnPkg::CountWidth-1:0] count
);
	import nnPkg::*;

	localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;

	payload_t mem [Depth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;

	// wrap at Depth, which need not be a power of two
	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
		if (ptr == PtrW'(Depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full = (count == CountWidth'(Depth));
	assign empty = (count == '0);
	assign head = mem[rdPtr]; // first-word fall-through

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: flist.f
design/nnPkg.sv
design/vectorQueue.sv
design/reluNode.sv
design/denseLayer.sv
design/apbFeatureWriter.sv
design/nnLayerTop.sv
tb/nnLayer_chk.sv
tb/nnLayerTb.sv

// File: run.sh
#!/bin/bash
# build and run the nnLayer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module nnLayerTb \
	-Mdir obj_dir -o nnLayerSim -f flist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/nnLayerSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Testbench passed" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

// File: tb/nnLayerTb.sv
`timescale 1ns/1ps
`default_nettype none

module nnLayerTb;
	import nnPkg::*;

	localparam int FeatureDepth = 4;
	localparam int ResultDepth = 4;
	localparam int MaxCycles = 64 * 40 + 1440; // 64 vectors of about 40 cycles plus margin
	localparam int MaxWait = 50; // access cycles before a transfer counts as hung

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [AddrWidth-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	int seed = 32'hc6a4;
	int cycles = 0;
	featureVec_t curFeat; // shadow of the feature registers
	resultVec_t expQ[$];

	nnLayerTop #(
		.FeatureDepth(FeatureDepth),
		.ResultDepth(ResultDepth)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MaxCycles)
		begin
			$display("ERROR: run did not finish within %0d cycles", MaxCycles);
			stopRun();
		end
		else if (u_dut.chk.failCount != 0)
		begin
			$display("ERROR: a checker assertion failed");
			stopRun();
		end
	end

	task automatic stopRun();
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkVal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
			stopRun();
		end
	endtask

	// expected layer output, every product and sum wraps at 32 bits
	function automatic resultVec_t modelLayer(input featureVec_t f);
		resultVec_t r;
		word_t sum;
		for (int n = 0; n < NumNodes; n++)
		begin
			sum = DefaultWeights[n].bias;
			for (int i = 0; i < NumInputs; i++)
				sum = sum + f.feat[i] * DefaultWeights[n].w[i];
			r.act[n] = (sum < 0) ? 32'sd0 : sum;
		end
		return r;
	endfunction

	// called 1 ns after a rising edge, returns at the same point
	task automatic apbXfer(input logic wr, input logic [AddrWidth-1:0] addr,
		input logic [31:0] wdata, input int maxWait,
		output logic [31:0] rdata, output logic err, output logic hung);
		int waited;
		waited = 0;
		hung = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1 penable = 1'b1;
		@(negedge clk);
		while (!pready && !hung)
		begin
			waited++;
			hung = (waited >= maxWait);
			@(negedge clk);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0; // a hung transfer is dropped here
		penable = 1'b0;
	endtask

	task automatic busAccess(input logic wr, input logic [AddrWidth-1:0] addr,
		input logic [31:0] wdata, input logic expectErr, output logic [31:0] rdata);
		logic err;
		logic hung;
		apbXfer(wr, addr, wdata, MaxWait, rdata, err, hung);
		if (hung)
		begin
			$display("ERROR: APB access to 0x%h never completed", addr);
			stopRun();
		end
		checkVal($sformatf("pslverr at 0x%h", addr), 32'(err), 32'(expectErr));
	endtask

	task automatic setFeature(input int i, input logic [31:0] value);
		logic [31:0] rd;
		busAccess(1'b1, AddrWidth'(FeatAddr + 4 * i), value, 1'b0, rd);
		curFeat.feat[i] = value;
	endtask

	task automatic commitVec();
		logic [31:0] rd;
		busAccess(1'b1, CommitAddr, 32'h0, 1'b0, rd);
		expQ.push_back(modelLayer(curFeat));
	endtask

	task automatic waitStatus(input logic [31:0] mask);
		logic [31:0] st;
		int polls;
		polls = 0;
		busAccess(1'b0, StatusAddr, 32'h0, 1'b0, st);
		while ((st & mask) != mask)
		begin
			polls++;
			if (polls > MaxWait)
			begin
				$display("ERROR: status bits 0x%h never came up", mask);
				stopRun();
			end
			busAccess(1'b0, StatusAddr, 32'h0, 1'b0, st);
		end
	endtask

	// oldest result against oldest model entry, then pop it
	task automatic drainOne();
		resultVec_t exp;
		logic [31:0] rd;
		waitStatus(32'h1);
		exp = expQ.pop_front();
		for (int n = 0; n < NumNodes; n++)
		begin
			busAccess(1'b0, AddrWidth'(ResultAddr + 4 * n), 32'h0, 1'b0, rd);
			checkVal($sformatf("result node %0d", n), rd, exp.act[n]);
		end
		busAccess(1'b1, PopAddr, 32'h0, 1'b0, rd);
	endtask

	// negative features small enough that no sum wraps
	task automatic clampVector();
		featureVec_t f;
		resultVec_t exp;
		int positives;
		int tries;
		positives = 0;
		tries = 0;
		while (positives == 0 && tries < 100)
		begin
			tries++;
			for (int i = 0; i < NumInputs; i++)
				f.feat[i] = -(($random(seed) & 32'h3fff) + 32'd2000);
			exp = modelLayer(f);
			for (int n = 0; n < NumNodes; n++)
				if (exp.act[n] != 0)
					positives++;
		end
		if (positives == 0)
		begin
			$display("ERROR: no negative vector with a positive node was found");
			stopRun();
		end
		for (int i = 0; i < NumInputs; i++)
			setFeature(i, f.feat[i]);
		commitVec();
		drainOne();
	endtask

	initial
	begin
		logic [31:0] rd;
		logic [31:0] statusBefore;
		logic err;
		logic hung;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		curFeat = '0;
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;

		busAccess(1'b0, StatusAddr, 32'h0, 1'b0, rd);
		checkVal("status after reset", rd, 32'h0);
		busAccess(1'b0, ResultAddr, 32'h0, 1'b1, rd); // result queue still empty

		repeat (40)
		begin
			for (int i = 0; i < NumInputs; i++)
				setFeature(i, $random(seed));
			commitVec();
			drainOne();
		end

		repeat (8)
			clampVector();

		// registers keep their values, resend the last vector as is
		for (int i = 0; i < NumInputs; i++)
		begin
			busAccess(1'b0, AddrWidth'(FeatAddr + 4 * i), 32'h0, 1'b0, rd);
			checkVal($sformatf("feature %0d", i), rd, curFeat.feat[i]);
		end
		commitVec();
		drainOne();

		// fill result queue and feature queue
		for (int k = 0; k < FeatureDepth + ResultDepth; k++)
		begin
			setFeature(0, $random(seed));
			commitVec();
		end
		waitStatus((32'(ResultDepth) << 8) | 32'h3);
		busAccess(1'b0, StatusAddr, 32'h0, 1'b0, rd);
		checkVal("status with queues full", rd, (32'(ResultDepth) << 8) | 32'h3);
		apbXfer(1'b1, CommitAddr, 32'h0, 8, rd, err, hung);
		if (!hung)
		begin
			$display("ERROR: commit into a full feature queue did not stall");
			stopRun();
		end
		while (expQ.size() > 0)
			drainOne();

		busAccess(1'b0, StatusAddr, 32'h0, 1'b0, statusBefore);
		checkVal("status after drain", statusBefore, 32'h0);
		busAccess(1'b1, 8'h80, 32'h1234, 1'b1, rd);
		busAccess(1'b0, 8'h80, 32'h0, 1'b1, rd);
		// unmapped write leaves every feature alone
		for (int i = 0; i < NumInputs; i++)
		begin
			busAccess(1'b0, AddrWidth'(FeatAddr + 4 * i), 32'h0, 1'b0, rd);
			checkVal($sformatf("feature %0d after 0x80", i), rd, curFeat.feat[i]);
		end
		busAccess(1'b0, StatusAddr, 32'h0, 1'b0, rd);
		checkVal("status after unmapped access", rd, statusBefore);

		if (u_dut.chk.failCount != 0)
		begin
			$display("ERROR: a checker assertion failed");
			stopRun();
		end
		else
		begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tb/nnLayer_chk.sv
`timescale 1ns/1ps
`default_nettype none

module nnLayerChk (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic featPush,
	input logic featFull,
	input logic featPop,
	input logic featEmpty,
	input logic resultPush,
	input logic resultFull,
	input logic resultPop,
	input logic resultEmpty
);

	int failCount = 0; // assertion failures so far

	// error only in the completing access cycle
	assert property (@(posedge clk) disable iff (reset) pslverr |-> (psel && penable && pready))
	else
	begin
		failCount++;
		$error("pslverr outside a completing access");
	end

	assert property (@(posedge clk) disable iff (reset) !(featPush && featFull))
	else
	begin
		failCount++;
		$error("feature queue pushed while full");
	end
	assert property (@(posedge clk) disable iff (reset) !(featPop && featEmpty))
	else
	begin
		failCount++;
		$error("feature queue popped while empty");
	end
	assert property (@(posedge clk) disable iff (reset) !(resultPush && resultFull))
	else
	begin
		failCount++;
		$error("result queue pushed while full");
	end
	assert property (@(posedge clk) disable iff (reset) !(resultPop && resultEmpty))
	else
	begin
		failCount++;
		$error("result queue popped while empty");
	end

endmodule

bind nnLayerTop nnLayerChk chk (
	.clk(clk),
	.reset(reset),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.featPush(featPush),
	.featFull(featFull),
	.featPop(featPop),
	.featEmpty(featEmpty),
	.resultPush(resultPush),
	.resultFull(resultFull),
	.resultPop(resultPop),
	.resultEmpty(resultEmpty)
);

`default_nettype wire
